// File: hw/jif_pkg.sv
package jif_pkg;

    localparam int word_width = 32;
    localparam int imm_width = 16;
    localparam int reg_count = 8;

    // Registers a to h, h last.
    typedef logic [2:0] reg_index_t;

    typedef enum logic [6:0] {
        op_nop       = 7'd0,
        op_add       = 7'd1,   // Flag is carry out.
        op_sub       = 7'd2,   // Flag is borrow.
        op_and       = 7'd3,
        op_or        = 7'd4,
        op_xor       = 7'd5,
        op_load_low  = 7'd6,
        op_store     = 7'd7,   // Memory at h gets ra.
        op_load_high = 7'd8,
        op_less      = 7'd9,
        op_equal     = 7'd10,
        op_branch    = 7'd11,  // Taken on flag of ra.
        op_jump      = 7'd12,
        op_shift     = 7'd13
    } opcode_t;

    // Instruction word, most significant field first.
    typedef struct packed {
        logic [imm_width-1:0] imm;
        reg_index_t           rd;
        reg_index_t           rb;
        reg_index_t           ra;
        opcode_t              op;
    } instr_t;

    typedef enum logic [1:0] {
        st_fetch   = 2'd0,
        st_execute = 2'd1,
        st_advance = 2'd2
    } cpu_state_t;

    // Register file write request.
    // Flag_enable alone writes only the flag, as compares do.
    typedef struct packed {
        logic                  enable;
        logic                  flag_enable;
        reg_index_t            index;
        logic [word_width-1:0] value;
        logic                  flag;
    } reg_write_t;

    typedef struct packed {
        logic                  taken;
        logic [word_width-1:0] target;
    } branch_t;

    // Single-cycle memory write strobe.
    typedef struct packed {
        logic                  strobe;
        logic [word_width-1:0] address;
        logic [word_width-1:0] data;
    } mem_write_t;

endpackage

// File: hw/jif_regfile.sv
`timescale 1ns/1ns

module jif_regfile (
    input  logic                           clock,
    input  logic                           rst,
    input  jif_pkg::reg_index_t            read_a,
    input  jif_pkg::reg_index_t            read_b,
    input  jif_pkg::reg_write_t            write,
    output logic [jif_pkg::word_width-1:0] value_a,
    output logic [jif_pkg::word_width-1:0] value_b,
    output logic [jif_pkg::word_width-1:0] value_h,
    output logic                           flag_a,
    output logic                           flag_b
);
    import jif_pkg::*;

    logic [word_width-1:0] words [reg_count];
    logic [reg_count-1:0]  flags;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < reg_count; i++)
            begin
                words[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (write.enable)
            begin
                words[write.index] <= write.value;
            end
            // Compares update the flag and leave the word alone.
            if (write.enable || write.flag_enable)
            begin
                flags[write.index] <= write.flag;
            end
        end
    end

    // Read ports.
    assign value_a = words[read_a];
    assign value_b = words[read_b];
    assign flag_a  = flags[read_a];
    assign flag_b  = flags[read_b];

    // Store address path.
    assign value_h = words[reg_count-1];

endmodule

// File: hw/jif_alu.sv
`timescale 1ns/1ns

module jif_alu (
    input  logic                           execute,
    input  jif_pkg::opcode_t               op,
    input  jif_pkg::reg_index_t            rd,
    input  logic [jif_pkg::imm_width-1:0]  imm,
    input  logic [jif_pkg::word_width-1:0] value_a,
    input  logic [jif_pkg::word_width-1:0] value_b,
    input  logic [jif_pkg::word_width-1:0] value_h,
    input  logic                           flag_a,
    output jif_pkg::reg_write_t            write,
    output jif_pkg::branch_t               branch,
    output jif_pkg::mem_write_t            store
);
    import jif_pkg::*;

    logic [word_width:0]   sum;         // Carry in top bit.
    logic [word_width:0]   difference;  // Borrow in top bit.
    logic [word_width-1:0] imm_low;
    logic [word_width-1:0] result;
    logic                  result_flag;
    logic                  zero_flag;
    logic                  writes_reg;
    logic                  writes_flag;

    assign sum        = {1'b0, value_a} + {1'b0, value_b};
    assign difference = {1'b0, value_a} - {1'b0, value_b};
    assign imm_low    = {{(word_width - imm_width){1'b0}}, imm};

    always_comb
    begin
        result      = '0;
        result_flag = 1'b0;
        zero_flag   = 1'b0;
        writes_reg  = 1'b0;
        writes_flag = 1'b0;
        case (op)
            op_add:
            begin
                result      = sum[word_width-1:0];
                result_flag = sum[word_width];
                writes_reg  = 1'b1;
            end
            op_sub:
            begin
                result      = difference[word_width-1:0];
                result_flag = difference[word_width];
                writes_reg  = 1'b1;
            end
            op_and:
            begin
                result     = value_a & value_b;
                zero_flag  = 1'b1;
                writes_reg = 1'b1;
            end
            op_or:
            begin
                result     = value_a | value_b;
                zero_flag  = 1'b1;
                writes_reg = 1'b1;
            end
            op_xor:
            begin
                result     = value_a ^ value_b;
                zero_flag  = 1'b1;
                writes_reg = 1'b1;
            end
            op_load_low:
            begin
                result     = imm_low;
                zero_flag  = 1'b1;
                writes_reg = 1'b1;
            end
            op_load_high:
            begin
                result     = {imm, value_a[word_width-imm_width-1:0]};
                zero_flag  = 1'b1;
                writes_reg = 1'b1;
            end
            op_shift:
            begin
                result     = value_a << value_b[4:0];
                zero_flag  = 1'b1;
                writes_reg = 1'b1;
            end
            op_less:
            begin
                result_flag = (value_a < value_b);  // Unsigned.
                writes_flag = 1'b1;
            end
            op_equal:
            begin
                result_flag = (value_a == value_b);
                writes_flag = 1'b1;
            end
            default:
            begin
                // Nop, store, branch, jump and unused codes.
                writes_reg = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        write.enable      = execute && writes_reg;
        write.flag_enable = execute && writes_flag;
        write.index       = rd;
        write.value       = result;
        write.flag        = zero_flag ? (result == '0) : result_flag;
    end

    // Used by control in advance only.
    always_comb
    begin
        case (op)
            op_branch: branch.taken = flag_a;
            op_jump:   branch.taken = 1'b1;
            default:   branch.taken = 1'b0;
        endcase
        branch.target = imm_low;
    end

    always_comb
    begin
        store.strobe  = execute && (op == op_store);
        store.address = value_h;
        store.data    = value_a;
    end

endmodule

// File: hw/jif_control.sv
`timescale 1ns/1ns

module jif_control #(
    parameter logic [jif_pkg::word_width-1:0] start_address = '0
) (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [jif_pkg::word_width-1:0] read_data,
    input  jif_pkg::branch_t               branch,
    output jif_pkg::instr_t                instr,
    output logic                           execute,
    output logic [jif_pkg::word_width-1:0] pc
);
    import jif_pkg::*;

    localparam logic [word_width-1:0] pc_step = 1;

    cpu_state_t            state;
    cpu_state_t            state_next;
    logic [word_width-1:0] pc_increment;
    logic [word_width-1:0] pc_next;

    // Fetch, execute, advance, then around again.
    always_comb
    begin
        case (state)
            st_fetch:   state_next = st_execute;
            st_execute: state_next = st_advance;
            default:    state_next = st_fetch;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= st_fetch;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Instruction latched at the end of fetch.
    always_ff @(posedge clock)
    begin
        if (state == st_fetch)
        begin
            instr <= instr_t'(read_data);
        end
    end

    assign pc_increment = pc + pc_step;

    // Branch target wins over the incrementer.
    assign pc_next = branch.taken ? branch.target : pc_increment;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= start_address;
        end
        else if (state == st_advance)
        begin
            pc <= pc_next;
        end
    end

    assign execute = (state == st_execute);  // Qualifies all writes.

endmodule

// File: hw/jif_cpu.sv
`timescale 1ns/1ns

module jif_cpu #(
    parameter logic [jif_pkg::word_width-1:0] start_address = '0
) (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [jif_pkg::word_width-1:0] read_data,
    output logic [jif_pkg::word_width-1:0] address,
    output logic [jif_pkg::word_width-1:0] write_data,
    output logic                           rw
);
    import jif_pkg::*;

    instr_t                instr;
    logic                  execute;
    logic [word_width-1:0] pc;
    branch_t               branch;
    reg_write_t            reg_write;
    mem_write_t            store;
    logic [word_width-1:0] value_a;
    logic [word_width-1:0] value_b;
    logic [word_width-1:0] value_h;
    logic                  flag_a;

    jif_control #(
        .start_address(start_address)
    ) u_jif_control (
        .clock    (clock),
        .rst      (rst),
        .read_data(read_data),
        .branch   (branch),
        .instr    (instr),
        .execute  (execute),
        .pc       (pc)
    );

    jif_regfile u_jif_regfile (
        .clock  (clock),
        .rst    (rst),
        .read_a (instr.ra),
        .read_b (instr.rb),
        .write  (reg_write),
        .value_a(value_a),
        .value_b(value_b),
        .value_h(value_h),
        .flag_a (flag_a),
        .flag_b ()
    );

    jif_alu u_jif_alu (
        .execute(execute),
        .op     (instr.op),
        .rd     (instr.rd),
        .imm    (instr.imm),
        .value_a(value_a),
        .value_b(value_b),
        .value_h(value_h),
        .flag_a (flag_a),
        .write  (reg_write),
        .branch (branch),
        .store  (store)
    );

    // Data address in execute, program counter otherwise.
    assign address    = execute ? store.address : pc;
    assign rw         = store.strobe;
    assign write_data = store.data;

endmodule

// File: testbench/jif_properties.sv
`timescale 1ns/1ns

module jif_properties (
    input logic clock,
    input logic rst,
    input logic rw
);
    int failure_count = 0;  // Read by the testbench at the end.

    rw_low_after_reset: assert property (@(posedge clock) rst |=> !rw)
    else
    begin
        $error("rw high in the cycle after reset");
        failure_count++;
    end

    rw_not_back_to_back: assert property (@(posedge clock) disable iff (rst) rw |=> !rw)
    else
    begin
        $error("rw high in two consecutive cycles");
        failure_count++;
    end

    // Advance and the next fetch never write.
    rw_gap_of_two: assert property (@(posedge clock) disable iff (rst) rw |=> !rw ##1 !rw)
    else
    begin
        $error("rw not followed by two quiet cycles");
        failure_count++;
    end

endmodule

// File: testbench/jif_checker.sv
`timescale 1ns/1ns

module jif_checker (
    input  logic                           clock,
    input  logic [jif_pkg::word_width-1:0] address,
    input  logic [jif_pkg::word_width-1:0] write_data,
    input  logic                           rw,
    output int                             store_count,
    output int                             error_count
);
    import jif_pkg::*;

    logic [word_width-1:0] expected_address[$];
    logic [word_width-1:0] expected_data[$];
    logic [word_width-1:0] want_address;
    logic [word_width-1:0] want_data;
    string                 test_label;
    int                    test_index;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;
    logic                  active;

    initial
    begin
        store_count  = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        active       = 1'b0;
    end

    task automatic begin_test(input int index, input string label);
        expected_address.delete();
        expected_data.delete();
        test_index  = index;
        test_label  = label;
        test_errors = 0;
        store_count = 0;
        active      = 1'b1;
    endtask

    task automatic expect_store(input logic [word_width-1:0] addr,
                                input logic [word_width-1:0] data);
        expected_address.push_back(addr);
        expected_data.push_back(data);
    endtask

    task automatic end_test();
        active = 1'b0;
        if (expected_address.size() != 0)
        begin
            $display("Test %0d: %0d expected stores never appeared", test_index,
                     expected_address.size());
            test_errors += expected_address.size();
        end
        error_count += test_errors;
        tests_run++;
        if (test_errors == 0)
        begin
            $display("Test %0d (%s): ok, %0d stores", test_index, test_label, store_count);
        end
        else
        begin
            $display("Test %0d (%s): FAILED, %0d errors", test_index, test_label, test_errors);
            tests_failed++;
        end
    endtask

    task automatic report_totals();
        $display("Totals: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
    endtask

    // Every write strobe is one store, in program order.
    always @(posedge clock)
    begin
        if (active && rw === 1'b1)
        begin
            store_count++;
            if (expected_address.size() == 0)
            begin
                $display("Test %0d: extra store of %h to address %h at %0t", test_index,
                         write_data, address, $time);
                test_errors++;
            end
            else
            begin
                want_address = expected_address.pop_front();
                want_data    = expected_data.pop_front();
                if (address !== want_address || write_data !== want_data)
                begin
                    $display("MISMATCH at %0t: test %0d stored %h to %h, expected %h to %h",
                             $time, test_index, write_data, address, want_data, want_address);
                    test_errors++;
                end
            end
        end
    end

endmodule

// File: testbench/jif_tb.sv
`timescale 1ns/1ns

module jif_tb;
    import jif_pkg::*;

    localparam int clock_period = 8;
    localparam int test_count   = 5;
    localparam int slot_count   = 12;
    localparam int pair_count   = 4;
    localparam int wait_cycles  = 40 * 3;  // 40 instructions.

    localparam reg_index_t reg_a = 3'd0;
    localparam reg_index_t reg_b = 3'd1;
    localparam reg_index_t reg_c = 3'd2;
    localparam reg_index_t reg_d = 3'd3;
    localparam reg_index_t reg_h = 3'd7;

    logic                  clock;
    logic                  rst;
    logic [word_width-1:0] read_data;
    logic [word_width-1:0] address;
    logic [word_width-1:0] write_data;
    logic                  rw;
    int                    store_count;
    int                    error_count;

    logic [word_width-1:0] memory [64];
    logic [word_width-1:0] program_words [test_count][slot_count];
    logic [word_width-1:0] expect_address [test_count][pair_count];
    logic [word_width-1:0] expect_data [test_count][pair_count];
    int                    store_total [test_count];
    string                 test_name [test_count];
    int                    build_test;
    int                    build_slot;
    logic [9:0]            lfsr;

    jif_cpu #(
        .start_address(32'd0)
    ) u_jif_cpu (
        .clock     (clock),
        .rst       (rst),
        .read_data (read_data),
        .address   (address),
        .write_data(write_data),
        .rw        (rw)
    );

    jif_checker u_jif_checker (
        .clock      (clock),
        .address    (address),
        .write_data (write_data),
        .rw         (rw),
        .store_count(store_count),
        .error_count(error_count)
    );

    bind jif_cpu jif_properties u_jif_properties (.clock(clock), .rst(rst), .rw(rw));

    initial
    begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    assign read_data = memory[address[5:0]];  // Combinational read.

    always @(posedge clock)
    begin
        if (rw === 1'b1)
        begin
            memory[address[5:0]] <= write_data;
        end
    end

    function automatic logic [31:0] encode(input opcode_t op, input reg_index_t rd,
                                           input reg_index_t ra, input reg_index_t rb,
                                           input logic [15:0] imm);
        return {imm, rd, rb, ra, op};
    endfunction

    // Taps 10 and 7.
    function automatic logic [15:0] draw_bits(input int count);
        logic [15:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr[9] ^ lfsr[6];
            lfsr     = {lfsr[8:0], feedback};
            bits     = {bits[14:0], feedback};
        end
        return bits;
    endfunction

    function automatic logic [31:0] model_result(input opcode_t op, input logic [31:0] x,
                                                 input logic [31:0] y);
        case (op)
            op_add:   return x + y;
            op_xor:   return x ^ y;
            op_shift: return x << y[4:0];
            default:  return '0;
        endcase
    endfunction

    task automatic new_test(input string name);
        build_test++;
        build_slot = 0;
        test_name[build_test] = name;
        store_total[build_test] = 0;
        for (int s = 0; s < slot_count; s++)
        begin
            program_words[build_test][s] = '0;
        end
    endtask

    task automatic emit(input opcode_t op, input reg_index_t rd, input reg_index_t ra,
                        input reg_index_t rb, input logic [15:0] imm);
        program_words[build_test][build_slot] = encode(op, rd, ra, rb, imm);
        build_slot++;
    endtask

    task automatic expect_pair(input logic [31:0] addr, input logic [31:0] data);
        expect_address[build_test][store_total[build_test]] = addr;
        expect_data[build_test][store_total[build_test]] = data;
        store_total[build_test]++;
    endtask

    task automatic build_table();
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        logic [15:0] r4;
        build_test = -1;
        new_test("constant build and logic ops");
        emit(op_load_low, reg_h, 0, 0, 16'd48);
        emit(op_load_low, reg_a, 0, 0, 16'h5678);
        emit(op_load_high, reg_a, reg_a, 0, 16'h1234);
        emit(op_store, 0, reg_a, 0, 0);
        emit(op_load_low, reg_b, 0, 0, 16'h0ff3);
        emit(op_sub, reg_c, reg_a, reg_b, 0);
        emit(op_store, 0, reg_c, 0, 0);
        emit(op_and, reg_c, reg_a, reg_b, 0);
        emit(op_store, 0, reg_c, 0, 0);
        emit(op_or, reg_c, reg_a, reg_b, 0);
        emit(op_store, 0, reg_c, 0, 0);
        emit(op_jump, 0, 0, 0, 16'd11);
        expect_pair(32'd48, 32'h1234_5678);
        expect_pair(32'd48, 32'h1234_4685);
        expect_pair(32'd48, 32'h0000_0670);
        expect_pair(32'd48, 32'h1234_5ffb);
        new_test("random add, xor and shift");
        r1 = draw_bits(16);
        r3 = draw_bits(16);
        r2 = draw_bits(16);
        r4 = draw_bits(16);
        emit(op_load_low, reg_h, 0, 0, 16'd52);
        emit(op_load_low, reg_a, 0, 0, r1);
        emit(op_load_high, reg_a, reg_a, 0, r3);
        emit(op_load_low, reg_b, 0, 0, r2);
        emit(op_load_high, reg_b, reg_b, 0, r4);
        emit(op_add, reg_c, reg_a, reg_b, 0);
        emit(op_store, 0, reg_c, 0, 0);
        emit(op_xor, reg_c, reg_a, reg_b, 0);
        emit(op_store, 0, reg_c, 0, 0);
        emit(op_shift, reg_c, reg_a, reg_b, 0);
        emit(op_store, 0, reg_c, 0, 0);
        emit(op_jump, 0, 0, 0, 16'd11);
        expect_pair(32'd52, model_result(op_add, {r3, r1}, {r4, r2}));
        expect_pair(32'd52, model_result(op_xor, {r3, r1}, {r4, r2}));
        expect_pair(32'd52, model_result(op_shift, {r3, r1}, {r4, r2}));
        new_test("carry steers branch");
        emit(op_load_high, reg_a, reg_a, 0, 16'hffff);
        emit(op_load_high, reg_b, reg_b, 0, 16'h0001);
        emit(op_add, reg_c, reg_a, reg_b, 0);
        emit(op_branch, 0, reg_c, 0, 16'd6);
        emit(op_store, 0, reg_a, 0, 0);       // Not-taken path.
        emit(op_jump, 0, 0, 0, 16'd7);
        emit(op_store, 0, reg_b, 0, 0);
        emit(op_jump, 0, 0, 0, 16'd7);
        expect_pair(32'd0, 32'h0001_0000);
        new_test("less and equal branches");
        emit(op_load_low, reg_a, 0, 0, 16'd5);
        emit(op_load_low, reg_b, 0, 0, 16'd9);
        emit(op_less, reg_c, reg_a, reg_b, 0);
        emit(op_branch, 0, reg_c, 0, 16'd5);
        emit(op_store, 0, reg_a, 0, 0);
        emit(op_equal, reg_d, reg_a, reg_b, 0);
        emit(op_branch, 0, reg_d, 0, 16'd8);
        emit(op_store, 0, reg_b, 0, 0);
        emit(op_jump, 0, 0, 0, 16'd8);
        expect_pair(32'd0, 32'd9);
        new_test("reset state and jump");
        emit(op_store, 0, reg_a, 0, 0);       // All zero after reset.
        emit(op_load_low, reg_h, 0, 0, 16'd58);
        emit(op_load_low, reg_a, 0, 0, 16'h0055);
        emit(op_jump, 0, 0, 0, 16'd5);
        emit(op_store, 0, reg_a, 0, 0);
        emit(op_load_low, reg_a, 0, 0, 16'h0066);
        emit(op_store, 0, reg_a, 0, 0);
        emit(op_jump, 0, 0, 0, 16'd7);
        expect_pair(32'd0, 32'd0);
        expect_pair(32'd58, 32'h0000_0066);
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < 64; i++)
        begin
            memory[i] <= {i[15:0] ^ 16'hc3c3, 16'h007f};  // Unused opcode runs as a nop.
        end
        for (int s = 0; s < slot_count; s++)
        begin
            memory[s] <= program_words[t][s];
        end
    endtask

    task automatic run_test(input int t);
        int waited;
        rst = 1'b1;
        load_program(t);
        u_jif_checker.begin_test(t, test_name[t]);
        for (int p = 0; p < store_total[t]; p++)
        begin
            u_jif_checker.expect_store(expect_address[t][p], expect_data[t][p]);
        end
        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;
        waited = 0;
        while (store_count < store_total[t] && waited < wait_cycles)
        begin
            @(posedge clock);
            #1;
            waited++;
        end
        u_jif_checker.end_test();
    endtask

    initial
    begin
        rst  = 1'b1;
        lfsr = 10'd10;
        build_table();
        load_program(0);
        @(posedge clock);
        #1;
        for (int t = 0; t < test_count; t++)
        begin
            run_test(t);
        end
        u_jif_checker.report_totals();
        if (error_count == 0 && u_jif_cpu.u_jif_properties.failure_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    initial
    begin
        #(test_count * 130 * clock_period);
        $display("Watchdog expired after %0d cycles, the run did not finish", test_count * 130);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: all.f
hw/jif_pkg.sv
hw/jif_regfile.sv
hw/jif_alu.sv
hw/jif_control.sv
hw/jif_cpu.sv
testbench/jif_properties.sv
testbench/jif_checker.sv
testbench/jif_tb.sv
